/* rtl/core_csr_file.sv */
// only the low address bits select a csr so higher addresses alias onto the eight slots
`include "core_params.svh"

module core_csr_file (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [11:0]           csr,
  output logic [`CORE_XLEN-1:0] csr_data,
  input  logic                  wr_en,
  input  logic [11:0]           wr_csr,
  input  logic [`CORE_XLEN-1:0] wr_data
);

  localparam int CW = $clog2(`CORE_NCSR);

  logic [`CORE_XLEN-1:0] csrs [`CORE_NCSR];

  assign csr_data = csrs[csr[CW-1:0]];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NCSR; i++) begin
        csrs[i] <= '0;
      end
    end else if (wr_en) begin
      csrs[wr_csr[CW-1:0]] <= wr_data;
    end
  end

endmodule

/* rtl/core_ex_bypass.sv */
// valid flags must already be qualified by the stage valids and rd zero never hits
`include "core_params.svh"

module core_ex_bypass (
  input  logic [$clog2(`CORE_NREG)-1:0] de_rs1,
  input  logic                          de_rs1_valid,
  input  logic [$clog2(`CORE_NREG)-1:0] de_rs2,
  input  logic                          de_rs2_valid,
  input  logic [11:0]                   de_csr,
  input  logic                          de_csr_valid,
  input  logic [$clog2(`CORE_NREG)-1:0] em_rd,
  input  logic                          em_reg_write,
  input  logic [11:0]                   em_csr,
  input  logic                          em_csr_write,
  input  logic [$clog2(`CORE_NREG)-1:0] mw_rd,
  input  logic                          mw_reg_write,
  input  logic                          mw_mem_data_valid,
  input  logic [11:0]                   mw_csr,
  input  logic                          mw_csr_write,
  output core_pkg::fwd_sel_t            rs1_sel,
  output core_pkg::fwd_sel_t            rs2_sel,
  output core_pkg::fwd_sel_t            csr_sel,
  input  logic                          de_start_handle,
  output logic                          start_handle
);
  import core_pkg::*;

  logic rs1_em_hit;
  logic rs1_mw_hit;
  logic rs2_em_hit;
  logic rs2_mw_hit;
  logic csr_em_hit;
  logic csr_mw_hit;
  logic mw_only;

  // --------------------
  // hazard compare
  assign rs1_em_hit = de_rs1_valid && em_reg_write && (de_rs1 == em_rd);
  assign rs1_mw_hit = de_rs1_valid && mw_reg_write && (de_rs1 == mw_rd);
  assign rs2_em_hit = de_rs2_valid && em_reg_write && (de_rs2 == em_rd);
  assign rs2_mw_hit = de_rs2_valid && mw_reg_write && (de_rs2 == mw_rd);
  assign csr_em_hit = de_csr_valid && em_csr_write && (de_csr == em_csr);
  assign csr_mw_hit = de_csr_valid && mw_csr_write && (de_csr == mw_csr);

  // a register taken from MW may still be waiting on memory
  assign mw_only      = (rs1_mw_hit && !rs1_em_hit) || (rs2_mw_hit && !rs2_em_hit);
  assign start_handle = de_start_handle && (!mw_only || mw_mem_data_valid);

  // --------------------
  // operand select, youngest writer wins
  assign rs1_sel = rs1_em_hit ? FWD_EM : (rs1_mw_hit ? FWD_MW : FWD_FILE);
  assign rs2_sel = rs2_em_hit ? FWD_EM : (rs2_mw_hit ? FWD_MW : FWD_FILE);
  assign csr_sel = csr_em_hit ? FWD_EM : (csr_mw_hit ? FWD_MW : FWD_FILE);

  // rd zero arrives with its write enable already cleared
  always_comb begin
    a_rd_zero: assert (!(em_reg_write === 1'b1 && em_rd === '0) &&
                       !(mw_reg_write === 1'b1 && mw_rd === '0));
  end

endmodule

/* rtl/core_ex_stage.sv */
// one load may wait in MW at a time and memory must answer each request exactly once
`include "core_params.svh"

module core_ex_stage (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          head_valid,
  input  core_pkg::op_t                 head_op,
  input  logic [$clog2(`CORE_NREG)-1:0] head_rd,
  input  logic [11:0]                   head_csr,
  output logic                          de_rs1_valid,
  output logic                          de_rs2_valid,
  output logic                          de_csr_valid,
  output logic                          de_start_handle,
  input  logic                          start_handle,
  input  core_pkg::fwd_sel_t            rs1_sel,
  input  core_pkg::fwd_sel_t            rs2_sel,
  input  core_pkg::fwd_sel_t            csr_sel,
  input  logic [`CORE_XLEN-1:0]         rs1_data,
  input  logic [`CORE_XLEN-1:0]         rs2_data,
  input  logic [`CORE_XLEN-1:0]         csr_data,
  output logic [$clog2(`CORE_NREG)-1:0] em_rd,
  output logic                          em_reg_write,
  output logic [11:0]                   em_csr,
  output logic                          em_csr_write,
  output logic [$clog2(`CORE_NREG)-1:0] mw_rd,
  output logic                          mw_reg_write,
  output logic                          mw_mem_data_valid,
  output logic [11:0]                   mw_csr,
  output logic                          mw_csr_write,
  output logic                          gpr_wr_en,
  output logic [$clog2(`CORE_NREG)-1:0] gpr_wr_rd,
  output logic [`CORE_XLEN-1:0]         gpr_wr_data,
  output logic                          csr_wr_en,
  output logic [11:0]                   csr_wr_csr,
  output logic [`CORE_XLEN-1:0]         csr_wr_data,
  output logic                          mem_req,
  output logic [`CORE_XLEN-1:0]         mem_addr,
  input  logic                          mem_rvalid,
  input  logic [`CORE_XLEN-1:0]         mem_rdata,
  output logic                          retire_valid,
  output logic [$clog2(`CORE_NREG)-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]         retire_data,
  output logic                          retire_csr_write,
  output logic [11:0]                   retire_csr,
  output logic [`CORE_XLEN-1:0]         retire_csr_data
);
  import core_pkg::*;

  localparam int XW = `CORE_XLEN;

  logic          em_valid;
  op_t           em_op;
  logic [XW-1:0] em_result;     // rd value, or address for a load
  logic [XW-1:0] em_csr_data;   // new csr value for a swap
  logic          mw_valid;
  op_t           mw_op;
  logic [XW-1:0] mw_result;
  logic [XW-1:0] mw_csr_data;
  logic [XW-1:0] mw_value;
  logic [XW-1:0] op_a;
  logic [XW-1:0] op_b;
  logic [XW-1:0] op_c;
  logic [XW-1:0] ex_result;
  logic          mw_done;
  logic          mw_free;
  logic          em_free;

  function automatic logic [XW-1:0] pick(fwd_sel_t sel, logic [XW-1:0] file_val,
                                         logic [XW-1:0] em_val, logic [XW-1:0] mw_val);
    case (sel)
      FWD_EM:  return em_val;
      FWD_MW:  return mw_val;
      default: return file_val;
    endcase
  endfunction

  // --------------------
  // decode and flow control
  assign de_rs1_valid = head_valid;   // every op reads rs1
  assign de_rs2_valid = head_valid && (head_op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND});
  assign de_csr_valid = head_valid && (head_op == OP_CSRW);

  assign mw_mem_data_valid = (mw_op != OP_LOAD) || mem_rvalid;
  assign mw_done           = mw_valid && mw_mem_data_valid;
  assign mw_free           = !mw_valid || mw_done;
  assign em_free           = !em_valid || mw_free;
  // loads never forward from EM
  assign de_start_handle   = head_valid && em_free && !(em_valid && em_op == OP_LOAD);

  // --------------------
  // operands and alu
  assign mw_value = (mw_op == OP_LOAD) ? mem_rdata : mw_result;
  assign op_a     = pick(rs1_sel, rs1_data, em_result, mw_value);
  assign op_b     = pick(rs2_sel, rs2_data, em_result, mw_value);
  assign op_c     = pick(csr_sel, csr_data, em_csr_data, mw_csr_data);

  always_comb begin
    case (head_op)
      OP_ADD:  ex_result = op_a + op_b;
      OP_SUB:  ex_result = op_a - op_b;
      OP_XOR:  ex_result = op_a ^ op_b;
      OP_AND:  ex_result = op_a & op_b;
      OP_CSRW: ex_result = op_c;      // old csr value goes to rd
      default: ex_result = op_a;      // load address
    endcase
  end

  // --------------------
  // EM and MW registers
  always_ff @(posedge clk) begin
    if (rst) begin
      em_valid <= 1'b0;
      mw_valid <= 1'b0;
      mem_req  <= 1'b0;
    end else begin
      if (em_free) begin
        em_valid <= start_handle;
      end
      if (mw_free) begin
        mw_valid <= em_valid;
      end
      mem_req <= em_valid && mw_free && (em_op == OP_LOAD);   // load enters MW
    end
  end

  always_ff @(posedge clk) begin
    if (start_handle) begin
      em_op       <= head_op;
      em_rd       <= head_rd;
      em_csr      <= head_csr;
      em_result   <= ex_result;
      em_csr_data <= op_a;
    end
    if (em_valid && mw_free) begin
      mw_op       <= em_op;
      mw_rd       <= em_rd;
      mw_csr      <= em_csr;
      mw_result   <= em_result;
      mw_csr_data <= em_csr_data;
    end
  end

  assign em_reg_write = em_valid && (em_rd != '0);
  assign em_csr_write = em_valid && (em_op == OP_CSRW);
  assign mw_reg_write = mw_valid && (mw_rd != '0);
  assign mw_csr_write = mw_valid && (mw_op == OP_CSRW);

  // --------------------
  // file writes, memory and retire
  assign gpr_wr_en   = mw_done && mw_reg_write;
  assign gpr_wr_rd   = mw_rd;
  assign gpr_wr_data = mw_value;
  assign csr_wr_en   = mw_done && mw_csr_write;
  assign csr_wr_csr  = mw_csr;
  assign csr_wr_data = mw_csr_data;
  assign mem_addr    = mw_result;   // held while the load waits

  assign retire_valid     = mw_done;
  assign retire_rd        = mw_rd;
  assign retire_data      = mw_value;
  assign retire_csr_write = mw_csr_write;
  assign retire_csr       = mw_csr;
  assign retire_csr_data  = mw_csr_data;

  // memory answers only a load waiting in MW
  a_rvalid_load: assert property (@(posedge clk) disable iff (rst)
                                  mem_rvalid |-> mw_valid && mw_op == OP_LOAD);

endmodule

/* rtl/core_ex_subsys.sv */
// issue sender starts with CORE_ISSUE_DEPTH credits and the retire port has no stall
`include "core_params.svh"

module core_ex_subsys (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_valid,
  input  core_pkg::op_t                 issue_op,
  input  logic [$clog2(`CORE_NREG)-1:0] issue_rd,
  input  logic [$clog2(`CORE_NREG)-1:0] issue_rs1,
  input  logic [$clog2(`CORE_NREG)-1:0] issue_rs2,
  input  logic [11:0]                   issue_csr,
  output logic                          issue_credit,
  output logic                          mem_req,
  output logic [`CORE_XLEN-1:0]         mem_addr,
  input  logic                          mem_rvalid,
  input  logic [`CORE_XLEN-1:0]         mem_rdata,
  output logic                          retire_valid,
  output logic [$clog2(`CORE_NREG)-1:0] retire_rd,
  output logic [`CORE_XLEN-1:0]         retire_data,
  output logic                          retire_csr_write,
  output logic [11:0]                   retire_csr,
  output logic [`CORE_XLEN-1:0]         retire_csr_data
);
  import core_pkg::*;

  localparam int RW = $clog2(`CORE_NREG);

  // --------------------
  // DE stage
  logic                  head_valid;
  op_t                   head_op;
  logic [RW-1:0]         head_rd;
  logic [RW-1:0]         head_rs1;
  logic [RW-1:0]         head_rs2;
  logic [11:0]           head_csr;
  logic                  de_rs1_valid;
  logic                  de_rs2_valid;
  logic                  de_csr_valid;
  logic                  de_start_handle;
  logic                  start_handle;
  fwd_sel_t              rs1_sel;
  fwd_sel_t              rs2_sel;
  fwd_sel_t              csr_sel;
  logic [`CORE_XLEN-1:0] rs1_data;
  logic [`CORE_XLEN-1:0] rs2_data;
  logic [`CORE_XLEN-1:0] csr_data;

  // --------------------
  // hazard and write back
  logic [RW-1:0]         em_rd;
  logic                  em_reg_write;
  logic [11:0]           em_csr;
  logic                  em_csr_write;
  logic [RW-1:0]         mw_rd;
  logic                  mw_reg_write;
  logic                  mw_mem_data_valid;
  logic [11:0]           mw_csr;
  logic                  mw_csr_write;
  logic                  gpr_wr_en;
  logic [RW-1:0]         gpr_wr_rd;
  logic [`CORE_XLEN-1:0] gpr_wr_data;
  logic                  csr_wr_en;
  logic [11:0]           csr_wr_csr;
  logic [`CORE_XLEN-1:0] csr_wr_data;

  core_issue_queue u_queue (
    .clk,
    .rst,
    .push     (issue_valid),
    .push_op  (issue_op),
    .push_rd  (issue_rd),
    .push_rs1 (issue_rs1),
    .push_rs2 (issue_rs2),
    .push_csr (issue_csr),
    .pop      (start_handle),   // dequeue as EM loads
    .head_valid,
    .head_op,
    .head_rd,
    .head_rs1,
    .head_rs2,
    .head_csr,
    .credit   (issue_credit)
  );

  core_gpr_file u_gpr (
    .clk,
    .rst,
    .rs1      (head_rs1),
    .rs2      (head_rs2),
    .rs1_data,
    .rs2_data,
    .wr_en    (gpr_wr_en),
    .wr_rd    (gpr_wr_rd),
    .wr_data  (gpr_wr_data)
  );

  core_csr_file u_csr (
    .clk,
    .rst,
    .csr      (head_csr),
    .csr_data,
    .wr_en    (csr_wr_en),
    .wr_csr   (csr_wr_csr),
    .wr_data  (csr_wr_data)
  );

  core_ex_bypass u_bypass (
    .de_rs1   (head_rs1),
    .de_rs2   (head_rs2),
    .de_csr   (head_csr),
    .*
  );

  core_ex_stage u_stage (.*);

endmodule

/* rtl/core_gpr_file.sv */
// x0 stays zero and a read does not see a write made in the same cycle
`include "core_params.svh"

module core_gpr_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [$clog2(`CORE_NREG)-1:0] rs1,
  input  logic [$clog2(`CORE_NREG)-1:0] rs2,
  output logic [`CORE_XLEN-1:0]         rs1_data,
  output logic [`CORE_XLEN-1:0]         rs2_data,
  input  logic                          wr_en,
  input  logic [$clog2(`CORE_NREG)-1:0] wr_rd,
  input  logic [`CORE_XLEN-1:0]         wr_data
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NREG];

  assign rs1_data = regs[rs1];   // bypass covers the MW write
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CORE_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_rd != '0) begin
      regs[wr_rd] <= wr_data;     // x0 never written
    end
  end

endmodule

/* rtl/core_issue_queue.sv */
// sender must hold a credit per push because a full queue has no back-pressure
`include "core_params.svh"

module core_issue_queue (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          push,
  input  core_pkg::op_t                 push_op,
  input  logic [$clog2(`CORE_NREG)-1:0] push_rd,
  input  logic [$clog2(`CORE_NREG)-1:0] push_rs1,
  input  logic [$clog2(`CORE_NREG)-1:0] push_rs2,
  input  logic [11:0]                   push_csr,
  input  logic                          pop,
  output logic                          head_valid,
  output core_pkg::op_t                 head_op,
  output logic [$clog2(`CORE_NREG)-1:0] head_rd,
  output logic [$clog2(`CORE_NREG)-1:0] head_rs1,
  output logic [$clog2(`CORE_NREG)-1:0] head_rs2,
  output logic [11:0]                   head_csr,
  output logic                          credit
);
  import core_pkg::*;

  localparam int PW = $clog2(`CORE_ISSUE_DEPTH);
  localparam int RW = $clog2(`CORE_NREG);
  localparam logic [PW:0] FULL_CNT = `CORE_ISSUE_DEPTH;

  op_t           op_q  [`CORE_ISSUE_DEPTH];
  logic [RW-1:0] rd_q  [`CORE_ISSUE_DEPTH];
  logic [RW-1:0] rs1_q [`CORE_ISSUE_DEPTH];
  logic [RW-1:0] rs2_q [`CORE_ISSUE_DEPTH];
  logic [11:0]   csr_q [`CORE_ISSUE_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;

  assign head_valid = (count != '0);
  assign head_op    = op_q[rd_ptr];
  assign head_rd    = rd_q[rd_ptr];
  assign head_rs1   = rs1_q[rd_ptr];
  assign head_rs2   = rs2_q[rd_ptr];
  assign head_csr   = csr_q[rd_ptr];

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]  <= push_op;
      rd_q[wr_ptr]  <= push_rd;
      rs1_q[wr_ptr] <= push_rs1;
      rs2_q[wr_ptr] <= push_rs2;
      csr_q[wr_ptr] <= push_csr;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + PW'(push);   // pointers wrap at the power of two
      rd_ptr <= rd_ptr + PW'(pop);
      count  <= count + (PW + 1)'(push) - (PW + 1)'(pop);
      credit <= pop;                  // one credit back per dequeue
    end
  end

  a_no_push_full: assert property (@(posedge clk) disable iff (rst) push |-> count != FULL_CNT);
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> head_valid);

endmodule

/* rtl/core_params.svh */
// issue queue depth must be a power of two and also sets the sender's starting credits
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// --------------------
// datapath sizes
`define CORE_XLEN 32          // data width
`define CORE_NREG 32          // general registers, 5-bit addresses
`define CORE_NCSR 8           // csr slots picked by the low address bits

// --------------------
// issue side
`define CORE_ISSUE_DEPTH 4    // queue entries and credits after reset

`endif

/* rtl/core_pkg.sv */
// encodings are fixed widths and shared by every execute module
package core_pkg;

  // operation code carried from issue to retire
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_XOR  = 3'd2,
    OP_AND  = 3'd3,
    OP_CSRW = 3'd4,   // swap rs1 into the csr and old csr into rd
    OP_LOAD = 3'd5
  } op_t;

  // operand source from the bypass unit
  typedef enum logic [1:0] {
    FWD_FILE = 2'd0,  // register or csr file
    FWD_EM   = 2'd1,
    FWD_MW   = 2'd2
  } fwd_sel_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the execute subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module core_ex_tb -f vlog.f -o sim_core_ex

./obj_dir/sim_core_ex | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
if ! grep -q "All tests passed" "$LOG"; then
  echo "simulation ended without a result, see $LOG"
  exit 1
fi
echo "simulation passed"

/* verification/core_ex_model.svh */
// included inside the testbench module body after instr_t and report_failure are declared
`ifndef CORE_EX_MODEL_SVH
`define CORE_EX_MODEL_SVH

// --------------------
// architectural state
logic [`CORE_XLEN-1:0] model_regs [`CORE_NREG];
logic [`CORE_XLEN-1:0] model_csrs [`CORE_NCSR];
logic [`CORE_XLEN-1:0] load_q [$];   // answered load data, oldest first

function automatic void reset_model();
  for (int i = 0; i < `CORE_NREG; i++) begin
    model_regs[i] = '0;
  end
  for (int i = 0; i < `CORE_NCSR; i++) begin
    model_csrs[i] = '0;
  end
  load_q.delete();
endfunction

// x0 always reads as zero
function automatic logic [`CORE_XLEN-1:0] read_reg(input logic [$clog2(`CORE_NREG)-1:0] rs);
  return (rs == '0) ? '0 : model_regs[rs];
endfunction

function automatic void record_load(input logic [`CORE_XLEN-1:0] data);
  load_q.push_back(data);
endfunction

function automatic logic [`CORE_XLEN-1:0] take_load();
  assert (load_q.size() > 0) else report_failure("load retired before memory answered it");
  if (load_q.size() == 0) begin
    return '0;
  end
  return load_q.pop_front();
endfunction

// --------------------
// one instruction in program order
function automatic void execute_instr(input instr_t ins,
                                      input logic [`CORE_XLEN-1:0] load_data,
                                      output logic [`CORE_XLEN-1:0] rd_val,
                                      output logic [`CORE_XLEN-1:0] csr_val);
  logic [`CORE_XLEN-1:0]         a;
  logic [`CORE_XLEN-1:0]         b;
  logic [$clog2(`CORE_NCSR)-1:0] slot;
  a       = read_reg(ins.rs1);
  b       = read_reg(ins.rs2);
  slot    = ins.csr[$clog2(`CORE_NCSR)-1:0];
  csr_val = a;                        // swap puts rs1 into the csr
  case (ins.op)
    OP_ADD:  rd_val = a + b;
    OP_SUB:  rd_val = a - b;
    OP_XOR:  rd_val = a ^ b;
    OP_AND:  rd_val = a & b;
    OP_CSRW: begin
      rd_val           = model_csrs[slot];
      model_csrs[slot] = a;
    end
    OP_LOAD: rd_val = load_data;
    default: rd_val = '0;
  endcase
  if (ins.rd != '0) begin
    model_regs[ins.rd] = rd_val;
  end
endfunction

`endif

/* verification/core_ex_tb.sv */
// memory answers one to six cycles after mem_req; the DUT is reset once and tests run back to back
`include "core_params.svh"

module core_ex_tb;
  import core_pkg::*;

  localparam int NUM_TESTS  = 6;
  localparam int NUM_INSTR  = 200;
  localparam int CLK_PERIOD = 10;
  localparam int XW         = `CORE_XLEN;
  localparam int RW         = $clog2(`CORE_NREG);
  localparam int WATCHDOG   = NUM_TESTS * NUM_INSTR * 10 * CLK_PERIOD;

  typedef struct packed {
    op_t           op;
    logic [RW-1:0] rd;
    logic [RW-1:0] rs1;
    logic [RW-1:0] rs2;
    logic [11:0]   csr;
  } instr_t;

  logic          clk;
  logic          rst;
  logic          issue_valid;
  op_t           issue_op;
  logic [RW-1:0] issue_rd;
  logic [RW-1:0] issue_rs1;
  logic [RW-1:0] issue_rs2;
  logic [11:0]   issue_csr;
  logic          issue_credit;
  logic          mem_req;
  logic [XW-1:0] mem_addr;
  logic          mem_rvalid;
  logic [XW-1:0] mem_rdata;
  logic          retire_valid;
  logic [RW-1:0] retire_rd;
  logic [XW-1:0] retire_data;
  logic          retire_csr_write;
  logic [11:0]   retire_csr;
  logic [XW-1:0] retire_csr_data;

  instr_t        pend_q [$];   // issued and not yet retired
  int            errors;
  int            tests_failed;
  int            credits;
  int            credits_back;
  int            issued;
  int            retired;
  logic          load_wait;
  int            load_delay;
  logic [RW-1:0] last_rd;
  logic [RW-1:0] prev_rd;
  logic          x0_dirty;     // a nonzero value was sent to x0
  int            x0_reads;

  function automatic void report_failure(input string msg);
    $display("ERROR time=%0t %s", $time, msg);
    errors++;
  endfunction

  function automatic void check_value(input string name, input logic [XW-1:0] got,
                                      input logic [XW-1:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
      errors++;
    end
  endfunction

  `include "core_ex_model.svh"

  core_ex_subsys UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired after %0d time units with instructions still in flight", WATCHDOG);
    $display("Some tests failed");
    $finish;
  end

  // --------------------
  // stimulus helpers
  function automatic int issue_gap(input int num);
    case (num)
      1:       return 0;    // back to back
      5:       return 50;
      2, 4:    return 10;
      default: return 20;
    endcase
  endfunction

  function automatic string test_name(input int num);
    case (num)
      1:       return "alu chain from EM";
      2:       return "distance two from MW";
      3:       return "load use";
      4:       return "csr swap chain";
      5:       return "credit protocol";
      default: return "x0 writes";
    endcase
  endfunction

  function automatic instr_t make_instr(input int num);
    instr_t ins;
    int     r;
    r       = $urandom_range(0, 99);
    ins.op  = op_t'($urandom_range(0, 3));
    ins.rd  = RW'($urandom_range(1, 7));
    ins.rs1 = RW'($urandom_range(0, 7));
    ins.rs2 = RW'($urandom_range(0, 7));
    ins.csr = 12'h7c0 + 12'($urandom_range(0, 7));
    case (num)
      1: begin
        ins.rs1 = last_rd;
        if (r < 15) ins.op = OP_LOAD;              // seeds the registers with data
      end
      2: begin
        ins.rd  = RW'($urandom_range(1, 3));       // small set so older writes collide
        ins.rs1 = prev_rd;
        ins.rs2 = r[0] ? prev_rd : last_rd;
        if (r < 15) ins.op = OP_LOAD;
      end
      3: begin
        ins.rs1 = last_rd;
        if (r < 50) ins.op = OP_LOAD;
      end
      4: begin
        ins.csr = 12'h7c0 + 12'($urandom_range(0, 1));
        if (r < 60) ins.op = OP_CSRW;
        else if (r < 80) ins.op = OP_LOAD;
      end
      5: begin
        if (r < 20) ins.op = OP_LOAD;
        else if (r < 35) ins.op = OP_CSRW;
      end
      default: begin
        if (r < 50) ins.rd = '0;
        if (r % 3 == 0) ins.rs1 = '0;
        if (r % 4 == 0) ins.rs2 = '0;
        if (r >= 80) ins.op = OP_LOAD;
      end
    endcase
    return ins;
  endfunction

  // --------------------
  // response checks
  function automatic void check_request();
    assert (!load_wait) else report_failure("memory request while another load still waits");
    assert (pend_q.size() > 0 && pend_q[0].op == OP_LOAD)
      else report_failure("memory request without a load as the oldest instruction");
    if (pend_q.size() > 0) begin
      check_value("mem_addr", mem_addr, read_reg(pend_q[0].rs1));
    end
    load_wait  = 1'b1;
    load_delay = $urandom_range(0, 5);
  endfunction

  function automatic void check_retire();
    instr_t        ins;
    logic [XW-1:0] ld;
    logic [XW-1:0] exp_data;
    logic [XW-1:0] exp_csr_data;
    assert (pend_q.size() > 0) else report_failure("retire with no instruction outstanding");
    if (pend_q.size() == 0) begin
      return;
    end
    ins = pend_q.pop_front();
    ld  = (ins.op == OP_LOAD) ? take_load() : '0;
    execute_instr(ins, ld, exp_data, exp_csr_data);
    retired++;
    if (x0_dirty && ins.rs1 == '0) begin
      x0_reads++;
    end
    if (ins.rd == '0 && exp_data != '0) begin
      x0_dirty = 1'b1;
    end
    check_value("retire_rd", XW'(retire_rd), XW'(ins.rd));
    check_value("retire_data", retire_data, exp_data);
    check_value("retire_csr_write", XW'(retire_csr_write), XW'(ins.op == OP_CSRW));
    if (ins.op == OP_CSRW) begin
      check_value("retire_csr", XW'(retire_csr), XW'(ins.csr));
      check_value("retire_csr_data", retire_csr_data, exp_csr_data);
    end
  endfunction

  // outputs sampled mid cycle
  initial begin
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (issue_credit) begin
          credits++;
          credits_back++;
        end
        assert (credits >= 0 && credits <= `CORE_ISSUE_DEPTH)
          else report_failure("sender credit count left the range zero to queue depth");
        if (mem_req) check_request();
        if (retire_valid) check_retire();
      end
    end
  end

  // memory responder, fresh data per answer
  initial begin
    logic [XW-1:0] data;
    forever begin
      @(posedge clk);
      data = $urandom();
      if (load_wait && load_delay == 0) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= data;
        record_load(data);
        load_wait = 1'b0;
      end else begin
        mem_rvalid <= 1'b0;
        mem_rdata  <= data;    // junk while idle
        if (load_wait) load_delay--;
      end
    end
  end

  // --------------------
  // test sequence
  task automatic run_test(input int num);
    int     err_start;
    int     gap_pct;
    instr_t ins;
    err_start    = errors;
    gap_pct      = issue_gap(num);
    issued       = 0;
    retired      = 0;
    credits_back = 0;
    x0_dirty     = 1'b0;
    x0_reads     = 0;
    while (issued < NUM_INSTR) begin
      @(posedge clk);
      if (credits > 0 && $urandom_range(0, 99) >= gap_pct) begin
        ins = make_instr(num);
        issue_valid <= 1'b1;
        issue_op    <= ins.op;
        issue_rd    <= ins.rd;
        issue_rs1   <= ins.rs1;
        issue_rs2   <= ins.rs2;
        issue_csr   <= ins.csr;
        pend_q.push_back(ins);
        credits--;
        issued++;
        prev_rd = last_rd;
        last_rd = ins.rd;
      end else begin
        issue_valid <= 1'b0;
      end
    end
    @(posedge clk);
    issue_valid <= 1'b0;
    while (retired < issued) @(posedge clk);
    assert (credits == `CORE_ISSUE_DEPTH)
      else report_failure("sender credits did not return to the queue depth");
    assert (credits_back == issued)
      else report_failure("credits returned differ from instructions issued");
    if (num == 6) begin
      assert (x0_reads > 0)
        else report_failure("no instruction read x0 after a nonzero write to x0");
    end
    if (errors == err_start) begin
      $display("test %0d %s: ok", num, test_name(num));
    end else begin
      $display("test %0d %s: FAILED with %0d errors", num, test_name(num), errors - err_start);
      tests_failed++;
    end
  endtask

  initial begin
    void'($urandom(2));
    rst          = 1'b1;
    issue_valid  = 1'b0;
    issue_op     = OP_ADD;
    issue_rd     = '0;
    issue_rs1    = '0;
    issue_rs2    = '0;
    issue_csr    = '0;
    mem_rvalid   = 1'b0;
    mem_rdata    = '0;
    errors       = 0;
    tests_failed = 0;
    credits      = `CORE_ISSUE_DEPTH;
    load_wait    = 1'b0;
    load_delay   = 0;
    last_rd      = '0;
    prev_rd      = '0;
    x0_dirty     = 1'b0;
    x0_reads     = 0;
    reset_model();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int t = 1; t <= NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run %0d, tests failed %0d, check errors %0d", NUM_TESTS, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+rtl
+incdir+verification
rtl/core_pkg.sv
rtl/core_issue_queue.sv
rtl/core_gpr_file.sv
rtl/core_csr_file.sv
rtl/core_ex_bypass.sv
rtl/core_ex_stage.sv
rtl/core_ex_subsys.sv
verification/core_ex_tb.sv
